// File: Makefile
# Verilator build and run for the output feature map buffer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_output_fm_buffer
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulation exited with $$status"; exit 1; fi
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dp_ram.sv
// ##########################################################
// one-write one-read RAM, registered read data
// ##########################################################
`timescale 1ns/1ps

module dp_ram
    import fm_pkg::*;
(
    input  logic          clk,
    input  logic [AW-1:0] wr_addr,
    input  logic [DW-1:0] wr_data,
    input  logic          wr_ena,
    input  logic [AW-1:0] rd_addr,
    output logic [DW-1:0] rd_data
);

    logic [DW-1:0] mem [BANK_WORDS];

    // same-cycle read of the write address sees the old word
    always_ff @(posedge clk) begin
        if (wr_ena) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];    // read every cycle
    end

endmodule

// File: fm_buffer_ctrl.sv
// ##########################################################
// buffer command sequencer, steers load/compute/store streams
// keeps the store output word under back-pressure
// ##########################################################
`timescale 1ns/1ps

module fm_buffer_ctrl
    import fm_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  cmd_t                 cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  logic                 ld_valid,
    output logic                 ld_ready,
    output logic [Y-1:0]         bank_wr_ena,
    output logic [Y-1:0]         bank_rd_ena,
    input  logic [Y-1:0][DW-1:0] bank_rd_data,
    output logic                 computing,
    input  logic                 acc_done,
    output logic [DW-1:0]        st_data,
    output logic                 st_valid,
    input  logic                 st_ready,
    output logic                 busy
);

    ctrl_state_t      state;
    logic [AW+BW-1:0] beat_cnt;    // tile beat, wraps back to 0 after a pass
    logic [BW-1:0]    beat_bank;
    logic             cmd_fire;
    logic             ld_fire;
    logic             out_free;    // word arriving next cycle has room
    logic             rd_go;
    logic             rd_done;     // every address issued
    logic             rd_pend;     // RAM word arrives this cycle
    logic [BW-1:0]    pend_bank;
    logic             take;

    assign cmd_ready = (state == ST_IDLE);
    assign busy      = (state != ST_IDLE);
    assign ld_ready  = (state == ST_LOAD);
    assign computing = (state == ST_COMPUTE);

    assign cmd_fire  = cmd_valid & cmd_ready;
    assign ld_fire   = ld_valid & ld_ready;
    assign beat_bank = beat_cnt[AW +: BW];    // upper bits pick the bank
    assign take      = st_valid & st_ready;

    // nothing in flight and the held word empty or leaving
    assign out_free = ~rd_pend & (~st_valid | st_ready);
    assign rd_go    = (cmd_fire && cmd == CMD_STORE) ||
                      (state == ST_STORE && !rd_done && out_free);

    always_comb begin
        for (int b = 0; b < Y; b++) begin
            bank_wr_ena[b] = ld_fire && (beat_bank == BW'(b));
            bank_rd_ena[b] = rd_go && (beat_bank == BW'(b));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
            rd_done  <= 1'b0;
            rd_pend  <= 1'b0;
            st_valid <= 1'b0;
        end else begin
            if (ld_fire || rd_go) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (rd_go && beat_cnt == (AW+BW)'(TILE_WORDS - 1)) begin
                rd_done <= 1'b1;
            end
            rd_pend <= rd_go;
            if (rd_pend) begin
                st_valid <= 1'b1;      // fresh RAM word fills the register
            end else if (take) begin
                st_valid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (cmd_fire) begin
                        case (cmd)
                            CMD_LOAD:    state <= ST_LOAD;
                            CMD_COMPUTE: state <= ST_COMPUTE;
                            CMD_STORE:   state <= ST_STORE;
                            default:     state <= ST_IDLE;   // unused code
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (ld_fire && beat_cnt == (AW+BW)'(TILE_WORDS - 1)) begin
                        state <= ST_IDLE;
                    end
                end
                ST_COMPUTE: begin
                    if (acc_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_STORE: begin
                    if (rd_done && !rd_pend && take) begin
                        state <= ST_DRAIN;    // final word just left
                    end
                end
                ST_DRAIN: begin
                    rd_done <= 1'b0;
                    state   <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        pend_bank <= beat_bank;
        if (rd_pend) begin
            st_data <= bank_rd_data[pend_bank];
        end
    end

endmodule

// File: fm_pkg.sv
// ##########################################################
// output feature map buffer shared definitions
// tile sizes, widths, command and state enums, stream structs
// ##########################################################
package fm_pkg;

    localparam int DW = 16;                     // data word width
    localparam int TN = 4;                      // tile channels
    localparam int TR = 4;                      // tile rows
    localparam int TC = 4;                      // tile columns
    localparam int Y  = 2;                      // number of banks

    // each bank keeps TN/Y whole channels
    localparam int BANK_WORDS = (TN / Y) * TR * TC;
    localparam int TILE_WORDS = TN * TR * TC;
    localparam int AW = $clog2(BANK_WORDS);     // bank address width
    localparam int BW = $clog2(Y);              // bank index width

    // host commands
    typedef enum logic [1:0] {
        CMD_LOAD    = 2'd0,   // stream in initial tile (bias)
        CMD_COMPUTE = 2'd1,   // accumulate partial sums
        CMD_STORE   = 2'd2    // stream tile out
    } cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_COMPUTE,
        ST_STORE,
        ST_DRAIN              // one cycle after last store word
    } ctrl_state_t;

    // one partial-sum beat, 23 bits
    typedef struct packed {
        logic [BW-1:0] bank;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic          last;  // final beat of the compute pass
    } psum_t;

    // internal read port of one bank
    typedef struct packed {
        logic [AW-1:0] addr;
        logic          ena;
    } bank_rd_t;

    // internal write port of one bank
    typedef struct packed {
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic          ena;
    } bank_wr_t;

endpackage

// File: output_fm_bank.sv
// ##########################################################
// one output feature map bank, TN/Y channels per bank
// sequential load/store addressing, internal ports in compute
// ##########################################################
`timescale 1ns/1ps

module output_fm_bank
    import fm_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic [DW-1:0] wr_data,
    input  logic          wr_ena,
    input  logic          rd_ena,
    output logic [DW-1:0] rd_data,
    input  logic          computing,
    input  bank_rd_t      inter_rd,
    input  bank_wr_t      inter_wr,
    output logic [DW-1:0] inter_rd_data
);

    logic [DW-1:0] wr_data_q;      // load data, one cycle late
    logic          wr_ena_q;
    logic [AW-1:0] ld_addr;
    logic [AW-1:0] st_addr;
    logic [AW-1:0] ram_wr_addr;
    logic [DW-1:0] ram_wr_data;
    logic          ram_wr_ena;
    logic [AW-1:0] ram_rd_addr;
    logic [DW-1:0] ram_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ena_q <= 1'b0;
        end else begin
            wr_ena_q <= wr_ena;
        end
    end

    always_ff @(posedge clk) begin
        wr_data_q <= wr_data;
    end

    // advances after each registered write, so beat 0 lands at 0
    seq_addr_counter ld_counter (
        .clk   (clk),
        .reset (reset),
        .ena   (wr_ena_q),
        .cnt   (ld_addr),
        .last  ()
    );

    // current address is read in the rd_ena cycle
    seq_addr_counter st_counter (
        .clk   (clk),
        .reset (reset),
        .ena   (rd_ena),
        .cnt   (st_addr),
        .last  ()
    );

    // accumulator owns the RAM while computing
    always_comb begin
        if (computing) begin
            ram_wr_addr = inter_wr.addr;
            ram_wr_data = inter_wr.data;
            ram_wr_ena  = inter_wr.ena;
        end else begin
            ram_wr_addr = ld_addr;
            ram_wr_data = wr_data_q;
            ram_wr_ena  = wr_ena_q;
        end
        ram_rd_addr = (computing && inter_rd.ena) ? inter_rd.addr : st_addr;
    end

    dp_ram ram (
        .clk     (clk),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .wr_ena  (ram_wr_ena),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_q)
    );

    assign rd_data       = ram_q;   // store path
    assign inter_rd_data = ram_q;   // accumulator path

endmodule

// File: output_fm_buffer.sv
// ##########################################################
// output feature map buffer top, Y banks of one output tile
// ##########################################################
`timescale 1ns/1ps

module output_fm_buffer
    import fm_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  cmd_t          cmd,
    input  logic          cmd_valid,
    output logic          cmd_ready,
    input  logic [DW-1:0] ld_data,
    input  logic          ld_valid,
    output logic          ld_ready,
    input  psum_t         psum,
    input  logic          psum_valid,
    output logic          psum_ready,
    output logic [DW-1:0] st_data,
    output logic          st_valid,
    input  logic          st_ready,
    output logic          busy
);

    logic [Y-1:0]         bank_wr_ena;
    logic [Y-1:0]         bank_rd_ena;
    logic [Y-1:0][DW-1:0] st_rd_data;     // bank words toward store
    logic [Y-1:0][DW-1:0] acc_rd_data;    // bank words toward accumulator
    bank_rd_t [Y-1:0]     bank_rd;
    bank_wr_t [Y-1:0]     bank_wr;
    logic                 computing;
    logic                 acc_done;

    fm_buffer_ctrl ctrl (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .ld_valid     (ld_valid),
        .ld_ready     (ld_ready),
        .bank_wr_ena  (bank_wr_ena),
        .bank_rd_ena  (bank_rd_ena),
        .bank_rd_data (st_rd_data),
        .computing    (computing),
        .acc_done     (acc_done),
        .st_data      (st_data),
        .st_valid     (st_valid),
        .st_ready     (st_ready),
        .busy         (busy)
    );

    psum_accumulator acc (
        .clk             (clk),
        .reset           (reset),
        .ena             (computing),
        .psum            (psum),
        .psum_valid      (psum_valid),
        .psum_ready      (psum_ready),
        .bank_rd         (bank_rd),
        .bank_rd_data    (acc_rd_data),
        .bank_wr         (bank_wr),
        .idle_after_last (acc_done)
    );

    // ld_data goes to every bank, only the enabled one keeps it
    for (genvar b = 0; b < Y; b++) begin : g_bank
        output_fm_bank bank (
            .clk           (clk),
            .reset         (reset),
            .wr_data       (ld_data),
            .wr_ena        (bank_wr_ena[b]),
            .rd_ena        (bank_rd_ena[b]),
            .rd_data       (st_rd_data[b]),
            .computing     (computing),
            .inter_rd      (bank_rd[b]),
            .inter_wr      (bank_wr[b]),
            .inter_rd_data (acc_rd_data[b])
        );
    end

endmodule

// File: psum_accumulator.sv
// ##########################################################
// partial-sum accumulator, read-add-write in two stages
// forwards the previous sum on back-to-back address hits
// ##########################################################
`timescale 1ns/1ps

module psum_accumulator
    import fm_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ena,             // high during compute
    input  psum_t                psum,
    input  logic                 psum_valid,
    output logic                 psum_ready,
    output bank_rd_t [Y-1:0]     bank_rd,
    input  logic [Y-1:0][DW-1:0] bank_rd_data,
    output bank_wr_t [Y-1:0]     bank_wr,
    output logic                 idle_after_last
);

    logic          accept;
    psum_t         s2_q;          // beat waiting for its RAM word
    logic          s2_vld;
    logic          fwd_vld;       // a write happened last cycle
    logic [BW-1:0] fwd_bank;
    logic [AW-1:0] fwd_addr;
    logic [DW-1:0] fwd_sum;
    logic          hit;
    logic [DW-1:0] base;
    logic [DW-1:0] sum;

    // never stalls, so ready only depends on the enable
    assign psum_ready = ena;
    assign accept     = psum_valid & psum_ready;

    // stage 1 read request to the addressed bank
    always_comb begin
        for (int b = 0; b < Y; b++) begin
            bank_rd[b].addr = psum.addr;
            bank_rd[b].ena  = accept && (psum.bank == BW'(b));
        end
    end

    // stage 2, RAM word is stale if the previous beat wrote the same place
    assign hit  = fwd_vld && (fwd_bank == s2_q.bank) && (fwd_addr == s2_q.addr);
    assign base = hit ? fwd_sum : bank_rd_data[s2_q.bank];
    assign sum  = base + s2_q.data;                      // wraps at DW

    always_comb begin
        for (int b = 0; b < Y; b++) begin
            bank_wr[b].addr = s2_q.addr;
            bank_wr[b].data = sum;
            bank_wr[b].ena  = s2_vld && (s2_q.bank == BW'(b));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_vld          <= 1'b0;
            fwd_vld         <= 1'b0;
            idle_after_last <= 1'b0;
        end else begin
            s2_vld          <= accept;
            fwd_vld         <= s2_vld;
            idle_after_last <= s2_vld & s2_q.last;    // last sum now in RAM
        end
    end

    always_ff @(posedge clk) begin
        s2_q     <= psum;
        fwd_bank <= s2_q.bank;
        fwd_addr <= s2_q.addr;
        fwd_sum  <= sum;
    end

endmodule

// File: seq_addr_counter.sv
// ##########################################################
// sequential bank address counter, wraps at bank capacity
// ##########################################################
`timescale 1ns/1ps

module seq_addr_counter
    import fm_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          ena,
    output logic [AW-1:0] cnt,
    output logic          last
);

    assign last = (cnt == AW'(BANK_WORDS - 1));   // sitting on final address

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (ena) begin
            if (last) begin
                cnt <= '0;                        // wrap so next pass starts at 0
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: tb.f
fm_pkg.sv
seq_addr_counter.sv
dp_ram.sv
output_fm_bank.sv
psum_accumulator.sv
fm_buffer_ctrl.sv
output_fm_buffer.sv
tb_output_fm_buffer.sv

// File: tb_output_fm_buffer.sv
// ##########################################################
// testbench for the output feature map buffer
// directed load, compute and store passes against a tile model
// ##########################################################
`timescale 1ns/1ps

module tb_output_fm_buffer
    import fm_pkg::*;
();

    localparam int N_PSUM    = 40;                  // random beats in accumulation test
    localparam int N_FWD     = 20;                  // beats in forwarding test
    localparam int PASS_LEN  = TILE_WORDS + 12;     // one load or store with slack
    localparam int TEST_LEN  = 10 + 2 * PASS_LEN + (2 * PASS_LEN + N_PSUM + 12)
                             + (PASS_LEN + N_FWD + 12) + 4 * PASS_LEN + (3 * PASS_LEN + 10);
    localparam int WATCHDOG_CYCLES = 4 * TEST_LEN;

    logic          clk = 1'b0;
    logic          reset;
    cmd_t          cmd;
    logic          cmd_valid;
    logic          cmd_ready;
    logic [DW-1:0] ld_data;
    logic          ld_valid;
    logic          ld_ready;
    psum_t         psum;
    logic          psum_valid;
    logic          psum_ready;
    logic [DW-1:0] st_data;
    logic          st_valid;
    logic          st_ready;
    logic          busy;

    logic [DW-1:0] model [TILE_WORDS];    // expected tile, bank-major order
    psum_t         beats [$];             // psums queued for the next compute
    integer        seed = 30331;
    int            errors = 0;
    int            checks = 0;
    time           load_done_at;          // edge of the final beat of the running load
    time           cmd_taken_at;          // edge where the waiting load command went in

    always #20 clk = ~clk;                // 40 ns period

    output_fm_buffer UUT (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .ld_data    (ld_data),
        .ld_valid   (ld_valid),
        .ld_ready   (ld_ready),
        .psum       (psum),
        .psum_valid (psum_valid),
        .psum_ready (psum_ready),
        .st_data    (st_data),
        .st_valid   (st_valid),
        .st_ready   (st_ready),
        .busy       (busy)
    );

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic psum_t make_beat(input logic [BW-1:0] b, input logic [AW-1:0] a,
                                        input logic [DW-1:0] d);
        psum_t p;
        p.bank = b;
        p.addr = a;
        p.data = d;
        p.last = 1'b0;                    // set when the beat is sent
        return p;
    endfunction

    // caller sits just after a rising edge; returns on the accept edge
    task automatic send_cmd(input cmd_t c);
        cmd       <= c;
        cmd_valid <= 1'b1;
        @(posedge clk);
        while (!cmd_ready) @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    // busy should drop within a few cycles of the last beat
    task automatic wait_idle();
        int n;
        n = 0;
        @(posedge clk);
        while (busy && n < 8) begin
            @(posedge clk);
            n++;
        end
        check_value("busy", DW'(busy), '0);
    endtask

    task automatic stream_load();
        logic [31:0] rnd;
        for (int k = 0; k < TILE_WORDS; k++) begin
            rnd      = $random(seed);
            model[k] = rnd[DW-1:0];       // beat k lands in bank k/BANK_WORDS
            ld_data  <= rnd[DW-1:0];
            ld_valid <= 1'b1;
            @(posedge clk);
            while (!ld_ready) @(posedge clk);
        end
        ld_valid <= 1'b0;
    endtask

    task automatic run_load();
        send_cmd(CMD_LOAD);
        stream_load();
    endtask

    // sends the queued beats, last flag on the final one
    task automatic run_compute();
        psum_t p;
        int    idx;
        send_cmd(CMD_COMPUTE);
        foreach (beats[i]) begin
            p        = beats[i];
            p.last   = (i == beats.size() - 1);
            idx      = int'(p.bank) * BANK_WORDS + int'(p.addr);
            model[idx] = model[idx] + p.data;     // wraps at 16 bits
            psum       <= p;
            psum_valid <= 1'b1;
            @(posedge clk);
            while (!psum_ready) @(posedge clk);
        end
        psum_valid <= 1'b0;
        beats.delete();
        wait_idle();
    endtask

    // collects the whole tile and checks order, values and hold under stall
    task automatic run_store(input bit rand_ready);
        logic [31:0]   rnd;
        logic [DW-1:0] held_data;
        logic          held;
        int            n;
        n         = 0;
        held      = 1'b0;
        held_data = '0;
        rnd       = $random(seed);
        st_ready  <= rand_ready ? rnd[0] : 1'b1;
        send_cmd(CMD_STORE);
        while (n < TILE_WORDS) begin
            @(posedge clk);
            if (held) begin               // stalled word must not move
                check_value("st_valid", DW'(st_valid), DW'(1));
                check_value("st_data", st_data, held_data);
            end
            if (st_valid && st_ready) begin
                check_value("st_data", st_data, model[n]);
                n++;
            end
            held      = st_valid && !st_ready;
            held_data = st_data;
            if (rand_ready) begin
                rnd      = $random(seed);
                st_ready <= rnd[0];
            end
        end
        st_ready <= 1'b0;
        wait_idle();
    endtask

    // idle outputs straight after reset
    task automatic check_reset_state();
        check_value("cmd_ready", DW'(cmd_ready), DW'(1));
        check_value("busy", DW'(busy), '0);
        check_value("st_valid", DW'(st_valid), '0);
        check_value("ld_ready", DW'(ld_ready), '0);
        check_value("psum_ready", DW'(psum_ready), '0);
    endtask

    // plain load then store
    task automatic load_then_store();
        run_load();
        run_store(1'b0);
    endtask

    task automatic accumulate_scattered();
        logic [31:0] rnd;
        run_load();
        for (int i = 0; i < N_PSUM; i++) begin
            rnd = $random(seed);
            beats.push_back(make_beat(rnd[DW+AW +: BW], rnd[DW +: AW], rnd[DW-1:0]));
        end
        run_compute();
        run_store(1'b0);
    endtask

    // back-to-back hits on one word, then alternating pairs, then one address in both banks
    task automatic accumulate_hits();
        logic [31:0] rnd;
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            beats.push_back(make_beat(BW'(1), AW'(7), rnd[DW-1:0]));
        end
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            beats.push_back(make_beat(BW'(0), AW'(5 + (i % 2)), rnd[DW-1:0]));
        end
        for (int i = 0; i < N_FWD - 16; i++) begin
            rnd = $random(seed);
            beats.push_back(make_beat(BW'(i % 2), AW'(9), rnd[DW-1:0]));
        end
        run_compute();
        run_store(1'b0);
    endtask

    // same tile out again with a stalling sink
    task automatic store_with_stall();
        run_store(1'b1);
    endtask

    // second load command raised mid-load must wait for idle
    task automatic load_while_busy();
        fork
            begin
                run_load();
                load_done_at = $time;
            end
            begin
                repeat (10) @(posedge clk);
                cmd       <= CMD_LOAD;
                cmd_valid <= 1'b1;
                @(posedge clk);
                while (!cmd_ready) begin
                    check_value("busy", DW'(busy), DW'(1));
                    @(posedge clk);
                end
                cmd_valid    <= 1'b0;
                cmd_taken_at = $time;
            end
        join
        checks++;
        assert (cmd_taken_at > load_done_at) else begin
            errors++;
            $display("load command was accepted before the running load finished");
        end
        stream_load();                    // must refill from address 0
        run_store(1'b0);
    endtask

    initial begin
        reset      <= 1'b1;
        cmd        <= CMD_LOAD;
        cmd_valid  <= 1'b0;
        ld_data    <= '0;
        ld_valid   <= 1'b0;
        psum       <= '0;
        psum_valid <= 1'b0;
        st_ready   <= 1'b0;
        load_done_at = 0;
        cmd_taken_at = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        check_reset_state();
        load_then_store();
        accumulate_scattered();
        accumulate_hits();
        store_with_stall();
        load_while_busy();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // hang guard sized from the test lengths
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, a handshake never completed",
                 WATCHDOG_CYCLES);
        $display("checks run: %0d, errors: %0d", checks, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
